//--- core_slice_pkg.sv
// Types and constants for the execution slice with flag bits at their x86 positions
package core_slice_pkg;

    localparam int WORD_W   = 16;
    localparam int SEL_W    = 3;
    localparam int NUM_REGS = 8;

    // Data word on every bus
    typedef logic [WORD_W-1:0] word_t;

    // Register number in x86 order, AX/AL=0 up to DI/BH=7
    typedef logic [SEL_W-1:0] reg_sel_t;

    // Flag word laid out like the x86 FLAGS register
    typedef logic [WORD_W-1:0] flags_t;

    localparam int CF_IDX = 0;
    localparam int PF_IDX = 2;
    localparam int ZF_IDX = 6;
    localparam int SF_IDX = 7;
    localparam int OF_IDX = 11;

    // Shift counts are read from CL
    localparam reg_sel_t CL_REG = 3'd1;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SELB,
        SHL,
        DIV,
        IDIV
    } alu_op_t;

    // Value written back to the destination register
    typedef enum logic [1:0] {
        Q,
        QUOTIENT,
        REMAINDER
    } wr_src_t;

    // One quotient bit per step
    localparam int DIV_STEPS_16 = 16;
    localparam int DIV_STEPS_8  = 8;

endpackage

//--- exec_if.sv
// Internal buses of the slice where valid and div_done are single-cycle pulses
`timescale 1ns/1ps

// Issued micro-op, held stable from valid until done
interface uop_if;
    import core_slice_pkg::*;

    logic     valid;
    alu_op_t  op;
    logic     is_8_bit;
    wr_src_t  wr_src;
    logic     wr_en;
    reg_sel_t rd_sel;
    word_t    imm;
    logic     use_imm;

    modport issue (
        output valid, op, is_8_bit, wr_src, wr_en, rd_sel, imm, use_imm
    );

    modport uses (
        input valid, op, is_8_bit, wr_src, wr_en, rd_sel, imm, use_imm
    );
endinterface

// Execute results towards write-back
interface wb_if;
    import core_slice_pkg::*;

    // Combinational, only meaningful while the micro-op is valid
    word_t  alu_out;
    flags_t alu_flags;

    word_t  quotient;
    word_t  remainder;
    logic   div_done;
    logic   div_error;

    modport produce (
        output alu_out, alu_flags, quotient, remainder, div_done, div_error
    );

    modport consume (
        input alu_out, alu_flags, quotient, remainder, div_done, div_error
    );
endinterface

//--- uop_decode.sv
// Accepts one micro-op per start pulse while idle and holds it until done
`timescale 1ns/1ps

module uop_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  core_slice_pkg::alu_op_t  alu_op,
    input  logic                     is_8_bit,
    input  core_slice_pkg::reg_sel_t ra_sel,
    input  core_slice_pkg::reg_sel_t rb_sel,
    input  core_slice_pkg::reg_sel_t rd_sel,
    input  logic                     rb_cl,
    input  logic                     use_imm,
    input  core_slice_pkg::word_t    imm,
    input  core_slice_pkg::wr_src_t  wr_src,
    input  logic                     reg_wr_en,
    input  logic                     done,
    output logic                     busy,
    output core_slice_pkg::reg_sel_t rf_ra_sel,
    output core_slice_pkg::reg_sel_t rf_rb_sel,
    uop_if.issue                     uop
);
    import core_slice_pkg::*;

    reg_sel_t ra_q;
    reg_sel_t rb_q;
    logic     rb_cl_q;
    logic     accept;

    // Starts during an operation are dropped
    assign accept = start && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Operation fields stay put until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            uop.op       <= alu_op;
            uop.is_8_bit <= is_8_bit;
            uop.wr_src   <= wr_src;
            uop.wr_en    <= reg_wr_en;
            uop.rd_sel   <= rd_sel;
            uop.imm      <= imm;
            uop.use_imm  <= use_imm;
            ra_q         <= ra_sel;
            rb_q         <= rb_sel;
            rb_cl_q      <= rb_cl;
        end
    end

    assign rf_ra_sel = ra_q;
    // Shift count source overrides the RB select
    assign rf_rb_sel = rb_cl_q ? CL_REG : rb_q;

endmodule

//--- register_file.sv
// Byte selects 4 to 7 reach the high bytes of AX to BX when is_8_bit is set
`timescale 1ns/1ps

module register_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     is_8_bit,
    input  core_slice_pkg::reg_sel_t ra_sel,
    input  core_slice_pkg::reg_sel_t rb_sel,
    input  core_slice_pkg::reg_sel_t wr_sel,
    input  core_slice_pkg::word_t    wr_val,
    input  logic                     wr_en,
    output core_slice_pkg::word_t    ra_val,
    output core_slice_pkg::word_t    rb_val
);
    import core_slice_pkg::*;

    word_t    regs [NUM_REGS];
    reg_sel_t ra_idx;
    reg_sel_t rb_idx;
    reg_sel_t wr_idx;

    // Byte selects only reach AX, CX, DX and BX
    function automatic reg_sel_t phys_idx(input reg_sel_t sel, input logic byte_mode);
        return byte_mode ? {1'b0, sel[1:0]} : sel;
    endfunction

    // Byte views are zero-extended
    function automatic word_t read_view(input word_t r, input logic hi, input logic byte_mode);
        if (!byte_mode) begin
            return r;
        end
        return hi ? {8'h00, r[15:8]} : {8'h00, r[7:0]};
    endfunction

    assign ra_idx = phys_idx(ra_sel, is_8_bit);
    assign rb_idx = phys_idx(rb_sel, is_8_bit);
    assign wr_idx = phys_idx(wr_sel, is_8_bit);

    assign ra_val = read_view(regs[ra_idx], ra_sel[2], is_8_bit);
    assign rb_val = read_view(regs[rb_idx], rb_sel[2], is_8_bit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            if (!is_8_bit) begin
                regs[wr_idx] <= wr_val;
            end else if (wr_sel[2]) begin
                // High byte write keeps the low byte
                regs[wr_idx][15:8] <= wr_val[7:0];
            end else begin
                regs[wr_idx][7:0] <= wr_val[7:0];
            end
        end
    end

endmodule

//--- alu_execute.sv
// Purely combinational and only meaningful while the issued micro-op is valid
`timescale 1ns/1ps

module alu_execute (
    uop_if.uses                    u,
    input  core_slice_pkg::word_t  ra_val,
    input  core_slice_pkg::word_t  rb_val,
    input  core_slice_pkg::flags_t flags_in,
    output core_slice_pkg::word_t  a_bus,
    output core_slice_pkg::word_t  b_bus,
    wb_if.produce                  w
);
    import core_slice_pkg::*;

    word_t       a_w;
    word_t       b_w;
    word_t       mask;
    word_t       res;
    logic [16:0] add_r;
    logic [16:0] sub_r;
    logic [31:0] shl_r;
    logic [4:0]  count;
    logic [4:0]  cf_bit;
    logic [3:0]  msb_i;
    logic        cf;
    logic        of;
    logic        upd;
    flags_t      f;

    assign a_bus = ra_val;
    assign b_bus = u.use_imm ? u.imm : rb_val;

    always_comb begin
        mask   = u.is_8_bit ? 16'h00ff : 16'hffff;
        msb_i  = u.is_8_bit ? 4'd7 : 4'd15;
        cf_bit = u.is_8_bit ? 5'd8 : 5'd16;
        a_w    = a_bus & mask;
        b_w    = b_bus & mask;
        count  = b_w[4:0];

        // Carry and borrow land just above the operand width
        add_r = {1'b0, a_w} + {1'b0, b_w};
        sub_r = {1'b0, a_w} - {1'b0, b_w};
        shl_r = {16'h0000, a_w} << count;

        cf  = 1'b0;
        of  = 1'b0;
        upd = 1'b1;
        case (u.op)
            ADD: begin
                res = add_r[15:0] & mask;
                cf  = add_r[cf_bit];
                of  = (a_w[msb_i] == b_w[msb_i]) && (res[msb_i] != a_w[msb_i]);
            end
            SUB: begin
                res = sub_r[15:0] & mask;
                cf  = sub_r[cf_bit];
                of  = (a_w[msb_i] != b_w[msb_i]) && (res[msb_i] != a_w[msb_i]);
            end
            AND: res = a_w & b_w;
            OR:  res = a_w | b_w;
            XOR: res = a_w ^ b_w;
            SHL: begin
                res = shl_r[15:0] & mask;
                // Last bit shifted out
                cf  = shl_r[cf_bit];
                of  = res[msb_i] ^ cf;
                upd = count != 5'd0;
            end
            SELB: begin
                res = b_w;
                upd = 1'b0;
            end
            default: begin
                res = '0;
                upd = 1'b0;
            end
        endcase

        f = flags_in;
        if (upd) begin
            f[CF_IDX] = cf;
            f[PF_IDX] = ~^res[7:0];
            f[ZF_IDX] = res == '0;
            f[SF_IDX] = res[msb_i];
            f[OF_IDX] = of;
        end

        w.alu_out   = res;
        w.alu_flags = f;
    end

endmodule

//--- divider.sv
// In 8-bit mode dividend and divisor are the low bytes of the A and B buses
`timescale 1ns/1ps

module divider (
    input  logic                  clk,
    input  logic                  arst_n,
    uop_if.uses                   u,
    input  core_slice_pkg::word_t a_bus,
    input  core_slice_pkg::word_t b_bus,
    wb_if.produce                 w
);
    import core_slice_pkg::*;

    logic        start;
    logic        signed_op;
    logic        dvd_neg;
    logic        dvs_neg;
    word_t       dvd_mag;
    word_t       dvs_mag;
    logic        running;
    logic        finish;
    logic [4:0]  cnt;
    // quo shifts dividend bits out at the top and quotient bits in at the bottom
    word_t       quo;
    word_t       rem;
    word_t       dvs;
    logic        is8_q;
    logic        signed_q;
    logic        q_neg;
    logic        r_neg;
    logic        div_zero;
    logic [16:0] shifted;
    logic [16:0] trial;
    word_t       mask;
    word_t       q_mag;
    word_t       lim;
    logic        q_over;

    assign start     = u.valid && (u.op == DIV || u.op == IDIV);
    assign signed_op = u.op == IDIV;

    // Magnitudes at the issued width
    always_comb begin
        if (u.is_8_bit) begin
            dvd_neg = signed_op && a_bus[7];
            dvs_neg = signed_op && b_bus[7];
            dvd_mag = {8'h00, dvd_neg ? 8'(-a_bus[7:0]) : a_bus[7:0]};
            dvs_mag = {8'h00, dvs_neg ? 8'(-b_bus[7:0]) : b_bus[7:0]};
        end else begin
            dvd_neg = signed_op && a_bus[15];
            dvs_neg = signed_op && b_bus[15];
            dvd_mag = dvd_neg ? -a_bus : a_bus;
            dvs_mag = dvs_neg ? -b_bus : b_bus;
        end
    end

    // Restoring step, a set top bit of trial means no subtract
    assign shifted = {rem, quo[15]};
    assign trial   = shifted - {1'b0, dvs};

    assign mask  = is8_q ? 16'h00ff : 16'hffff;
    assign q_mag = quo & mask;
    assign lim   = is8_q ? 16'h0080 : 16'h8000;
    // Negative quotients may reach one step further
    assign q_over = signed_q && (q_neg ? q_mag > lim : q_mag >= lim);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running     <= 1'b0;
            finish      <= 1'b0;
            cnt         <= '0;
            w.div_done  <= 1'b0;
            w.div_error <= 1'b0;
        end else begin
            w.div_done <= finish;
            finish     <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= u.is_8_bit ? 5'(DIV_STEPS_8) : 5'(DIV_STEPS_16);
            end else if (running) begin
                cnt <= cnt - 5'd1;
                if (cnt == 5'd1) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
            if (finish) begin
                w.div_error <= div_zero || q_over;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo      <= u.is_8_bit ? {dvd_mag[7:0], 8'h00} : dvd_mag;
            rem      <= '0;
            dvs      <= dvs_mag;
            is8_q    <= u.is_8_bit;
            signed_q <= signed_op;
            q_neg    <= dvd_neg ^ dvs_neg;
            r_neg    <= dvd_neg;
            div_zero <= dvs_mag == '0;
        end else if (running) begin
            quo <= {quo[14:0], ~trial[16]};
            rem <= trial[16] ? shifted[15:0] : trial[15:0];
        end
        // Truncate toward zero, remainder follows the dividend sign
        if (finish) begin
            w.quotient  <= (q_neg ? -q_mag : q_mag) & mask;
            w.remainder <= (r_neg ? -rem : rem) & mask;
        end
    end

endmodule

//--- result_writeback.sv
// Flags change only for ALU ops and a failed divide never writes its register
`timescale 1ns/1ps

module result_writeback (
    input  logic                     clk,
    input  logic                     arst_n,
    uop_if.uses                      u,
    wb_if.consume                    w,
    output core_slice_pkg::reg_sel_t wr_sel,
    output core_slice_pkg::word_t    wr_val,
    output logic                     wr_en,
    output core_slice_pkg::word_t    result,
    output core_slice_pkg::flags_t   flags,
    output logic                     div_error,
    output logic                     done
);
    import core_slice_pkg::*;

    logic is_div;
    logic alu_fire;
    logic fire;
    logic div_fail;

    assign is_div   = u.op == DIV || u.op == IDIV;
    assign alu_fire = u.valid && !is_div;
    assign fire     = alu_fire || w.div_done;
    assign div_fail = w.div_done && w.div_error;

    always_comb begin
        case (u.wr_src)
            QUOTIENT:  wr_val = w.quotient;
            REMAINDER: wr_val = w.remainder;
            default:   wr_val = w.alu_out;
        endcase
    end

    // Register write lands on the same edge that raises done
    assign wr_sel = u.rd_sel;
    assign wr_en  = fire && u.wr_en && !div_fail;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done      <= 1'b0;
            div_error <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            done <= fire;
            if (fire) begin
                result    <= wr_val;
                div_error <= div_fail;
            end
            if (alu_fire) begin
                flags <= w.alu_flags;
            end
        end
    end

endmodule

//--- core_slice.sv
// One micro-op in flight at a time and the caller must wait for done
`timescale 1ns/1ps

module core_slice (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  core_slice_pkg::alu_op_t  alu_op,
    input  logic                     is_8_bit,
    input  core_slice_pkg::reg_sel_t ra_sel,
    input  core_slice_pkg::reg_sel_t rb_sel,
    input  core_slice_pkg::reg_sel_t rd_sel,
    input  logic                     rb_cl,
    input  logic                     use_imm,
    input  core_slice_pkg::word_t    imm,
    input  core_slice_pkg::wr_src_t  wr_src,
    input  logic                     reg_wr_en,
    output logic                     busy,
    output logic                     done,
    output core_slice_pkg::word_t    result,
    output core_slice_pkg::flags_t   flags,
    output logic                     div_error
);
    import core_slice_pkg::*;

    reg_sel_t rf_ra_sel;
    reg_sel_t rf_rb_sel;
    reg_sel_t wr_sel;
    word_t    ra_val;
    word_t    rb_val;
    word_t    a_bus;
    word_t    b_bus;
    word_t    wr_val;
    logic     wr_en;

    uop_if uop ();
    wb_if  wb ();

    uop_decode u_decode (
        .clk, .arst_n, .start, .alu_op, .is_8_bit, .ra_sel, .rb_sel, .rd_sel,
        .rb_cl, .use_imm, .imm, .wr_src, .reg_wr_en, .done, .busy,
        .rf_ra_sel, .rf_rb_sel, .uop(uop.issue)
    );

    register_file u_regs (
        .clk, .arst_n, .is_8_bit(uop.is_8_bit), .ra_sel(rf_ra_sel), .rb_sel(rf_rb_sel),
        .wr_sel, .wr_val, .wr_en, .ra_val, .rb_val
    );

    alu_execute u_alu (
        .u(uop.uses), .ra_val, .rb_val, .flags_in(flags), .a_bus, .b_bus, .w(wb.produce)
    );

    divider u_div (
        .clk, .arst_n, .u(uop.uses), .a_bus, .b_bus, .w(wb.produce)
    );

    result_writeback u_wb (
        .clk, .arst_n, .u(uop.uses), .w(wb.consume), .wr_sel, .wr_val, .wr_en,
        .result, .flags, .div_error, .done
    );

endmodule

//--- core_slice_chk.sv
// Latency is checked for ALU ops only and assumes one micro-op in flight
`timescale 1ns/1ps

module core_slice_chk (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    start,
    input logic                    busy,
    input logic                    done,
    input core_slice_pkg::alu_op_t alu_op,
    input core_slice_pkg::alu_op_t held_op,
    input core_slice_pkg::word_t   held_imm
);
    import core_slice_pkg::*;

    // Number of failed properties
    int fails = 0;

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !done && !busy)
        else begin
            fails++;
            $error("done or busy high during reset");
        end

    a_done_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(busy))
        else begin
            fails++;
            $error("done without busy in the previous cycle");
        end

    // Accepted ALU op completes on the second edge
    a_alu_latency: assert property (@(posedge clk) disable iff (!arst_n)
        start && !busy && !(alu_op inside {DIV, IDIV}) |-> ##1 !done ##1 done)
        else begin
            fails++;
            $error("ALU op did not finish two cycles after its start");
        end

    a_start_ignored: assert property (@(posedge clk) disable iff (!arst_n)
        start && busy |=> $stable(held_op) && $stable(held_imm))
        else begin
            fails++;
            $error("start while busy changed the held micro-op");
        end

endmodule

bind core_slice core_slice_chk u_chk (
    .clk, .arst_n, .start, .busy, .done, .alu_op,
    .held_op(uop.op), .held_imm(uop.imm)
);

//--- tb_core_slice.sv
// Expects all registers and flags at zero after reset and leaves the result of a failed divide unchecked
`timescale 1ns/1ps

module tb_core_slice;
    import core_slice_pkg::*;

    localparam int WAIT_LIMIT = 60;

    typedef struct {
        alu_op_t  op;
        logic     b8;
        reg_sel_t ra;
        reg_sel_t rb;
        reg_sel_t rd;
        logic     cl;
        logic     ui;
        word_t    imm;
        wr_src_t  src;
        logic     we;
        logic     poke;
        word_t    e_res;
        flags_t   e_flags;
        logic     e_err;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     start;
    alu_op_t  alu_op;
    logic     is_8_bit;
    reg_sel_t ra_sel;
    reg_sel_t rb_sel;
    reg_sel_t rd_sel;
    logic     rb_cl;
    logic     use_imm;
    word_t    imm;
    wr_src_t  wr_src;
    logic     reg_wr_en;
    logic     busy;
    logic     done;
    word_t    result;
    flags_t   flags;
    logic     div_error;

    row_t   rows[$];
    word_t  mregs[8];
    flags_t mflags;
    int     errors;
    logic   timed_out;

    core_slice UUT (.*);

    always #20 clk = ~clk;

    function automatic row_t make_row(alu_op_t op, logic b8, reg_sel_t ra, reg_sel_t rb,
                                      reg_sel_t rd, logic ui, word_t v, wr_src_t src);
        row_t r;
        r = '{op, b8, ra, rb, rd, 1'b0, ui, v, src, 1'b1, 1'b0, '0, '0, 1'b0};
        return r;
    endfunction

    task automatic load_reg(input reg_sel_t rd, input logic b8, input word_t v);
        rows.push_back(make_row(SELB, b8, 3'd0, 3'd0, rd, 1'b1, v, Q));
    endtask

    // Byte selects 4..7 are the high halves of registers 0..3
    function automatic word_t reg_view(input reg_sel_t sel, input logic b8);
        if (!b8) begin
            return mregs[sel];
        end
        return (sel < 4) ? {8'h00, mregs[sel][7:0]} : {8'h00, mregs[sel - 4][15:8]};
    endfunction

    function automatic int to_signed(input int v, input int w);
        return v[w-1] ? v - (1 << w) : v;
    endfunction

    // Reference model, updates the model registers and flags as it goes
    function automatic row_t predict(input row_t r);
        int     w;
        int     mask;
        int     smax;
        int     a;
        int     b;
        int     dvd;
        int     dvs;
        int     q;
        longint full;
        logic   cf;
        logic   of;
        logic   upd;
        word_t  res;
        w    = r.b8 ? 8 : 16;
        mask = (1 << w) - 1;
        smax = mask >> 1;
        a    = int'(reg_view(r.ra, r.b8)) & mask;
        b    = int'(r.ui ? r.imm : reg_view(r.cl ? CL_REG : r.rb, r.b8)) & mask;
        full = 0;
        cf   = 1'b0;
        of   = 1'b0;
        upd  = 1'b1;
        case (r.op)
            ADD: begin
                full = a + b;
                cf   = full > mask;
                of   = (to_signed(a, w) + to_signed(b, w) > smax) ||
                       (to_signed(a, w) + to_signed(b, w) < -smax - 1);
            end
            SUB: begin
                full = a - b;
                cf   = a < b;
                of   = (to_signed(a, w) - to_signed(b, w) > smax) ||
                       (to_signed(a, w) - to_signed(b, w) < -smax - 1);
            end
            AND: full = a & b;
            OR:  full = a | b;
            XOR: full = a ^ b;
            SHL: begin
                full = longint'(a) << (b & 31);
                cf   = full[w];
                of   = full[w-1] ^ cf;
                upd  = (b & 31) != 0;
            end
            DIV, IDIV: begin
                upd = 1'b0;
                dvd = (r.op == IDIV) ? to_signed(a, w) : a;
                dvs = (r.op == IDIV) ? to_signed(b, w) : b;
                if (dvs == 0) begin
                    r.e_err = 1'b1;
                end else begin
                    q       = dvd / dvs;
                    r.e_err = (r.op == IDIV) ? (q > smax || q < -smax - 1) : (q > mask);
                    full    = (r.src == REMAINDER) ? dvd % dvs : q;
                end
            end
            default: begin
                full = b;
                upd  = 1'b0;
            end
        endcase
        res     = word_t'(full & mask);
        r.e_res = res;
        if (upd) begin
            mflags[CF_IDX] = cf;
            mflags[PF_IDX] = ~^res[7:0];
            mflags[ZF_IDX] = res == 16'h0000;
            mflags[SF_IDX] = res[w-1];
            mflags[OF_IDX] = of;
        end
        r.e_flags = mflags;
        if (r.we && !r.e_err) begin
            if (!r.b8) begin
                mregs[r.rd] = res;
            end else if (r.rd < 4) begin
                mregs[r.rd][7:0] = res[7:0];
            end else begin
                mregs[r.rd - 4][15:8] = res[7:0];
            end
        end
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        // Word and byte writes, read back through RB
        load_reg(3'd0, 1'b0, 16'h1234);
        load_reg(3'd3, 1'b0, 16'ha5c3);
        load_reg(3'd4, 1'b1, 16'h0077);
        load_reg(3'd3, 1'b1, 16'h0099);
        rows.push_back(make_row(SELB, 1'b0, 3'd0, 3'd0, 3'd6, 1'b0, '0, Q));
        rows.push_back(make_row(SELB, 1'b1, 3'd0, 3'd7, 3'd5, 1'b0, '0, Q));
        rows.push_back(make_row(SELB, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0, '0, Q));
        // Carry, borrow and signed overflow edges
        load_reg(3'd0, 1'b0, 16'h7fff);
        rows.push_back(make_row(ADD, 1'b0, 3'd0, 3'd0, 3'd2, 1'b1, 16'h0001, Q));
        rows.push_back(make_row(ADD, 1'b0, 3'd2, 3'd0, 3'd2, 1'b1, 16'h8000, Q));
        rows.push_back(make_row(SUB, 1'b0, 3'd2, 3'd0, 3'd2, 1'b1, 16'h0001, Q));
        load_reg(3'd3, 1'b1, 16'h007f);
        rows.push_back(make_row(ADD, 1'b1, 3'd3, 3'd0, 3'd3, 1'b1, 16'h0001, Q));
        rows.push_back(make_row(SUB, 1'b1, 3'd3, 3'd0, 3'd3, 1'b1, 16'h0001, Q));
        for (int i = 0; i < 6; i++) begin
            load_reg(3'd0, 1'b0, word_t'($urandom));
            load_reg(3'd2, 1'b0, word_t'($urandom));
            for (int k = 0; k < 5; k++) begin
                rows.push_back(make_row(alu_op_t'(k), i[0], 3'd0, 3'd2, 3'd3, 1'b0, '0, Q));
            end
        end
        // Shift count from CL, RB select is overridden
        load_reg(3'd0, 1'b0, word_t'($urandom));
        for (int i = 0; i < 4; i++) begin
            load_reg(3'd1, 1'b1, word_t'(i * 5));
            r    = make_row(SHL, i[0], 3'd0, 3'd6, 3'd0, 1'b0, '0, Q);
            r.cl = 1'b1;
            rows.push_back(r);
        end
        load_reg(3'd0, 1'b0, 16'd100);
        load_reg(3'd2, 1'b0, 16'd7);
        rows.push_back(make_row(DIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, QUOTIENT));
        rows.push_back(make_row(DIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, REMAINDER));
        load_reg(3'd0, 1'b0, 16'hff9c);
        rows.push_back(make_row(IDIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, QUOTIENT));
        rows.push_back(make_row(IDIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, REMAINDER));
        load_reg(3'd2, 1'b1, 16'h00f9);
        rows.push_back(make_row(IDIV, 1'b1, 3'd0, 3'd2, 3'd7, 1'b0, '0, QUOTIENT));
        rows.push_back(make_row(IDIV, 1'b1, 3'd0, 3'd2, 3'd5, 1'b0, '0, REMAINDER));
        rows.push_back(make_row(DIV, 1'b1, 3'd0, 3'd2, 3'd7, 1'b0, '0, QUOTIENT));
        for (int i = 0; i < 8; i++) begin
            load_reg(3'd0, 1'b0, word_t'($urandom));
            load_reg(3'd2, 1'b0, word_t'($urandom % 300));
            rows.push_back(make_row(i[1] ? IDIV : DIV, i[0], 3'd0, 3'd2, 3'd6, 1'b0, '0,
                                    i[2] ? REMAINDER : QUOTIENT));
        end
        // Divide errors must leave the destination alone
        load_reg(3'd6, 1'b0, 16'h5555);
        load_reg(3'd2, 1'b0, 16'h0000);
        rows.push_back(make_row(DIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, QUOTIENT));
        load_reg(3'd0, 1'b0, 16'h8000);
        load_reg(3'd2, 1'b0, 16'hffff);
        rows.push_back(make_row(IDIV, 1'b0, 3'd0, 3'd2, 3'd6, 1'b0, '0, REMAINDER));
        rows.push_back(make_row(SELB, 1'b0, 3'd0, 3'd6, 3'd1, 1'b0, '0, Q));
        load_reg(3'd0, 1'b1, 16'h0080);
        rows.push_back(make_row(IDIV, 1'b1, 3'd0, 3'd2, 3'd4, 1'b0, '0, QUOTIENT));
        rows.push_back(make_row(SELB, 1'b0, 3'd0, 3'd0, 3'd3, 1'b0, '0, Q));
        r      = make_row(OR, 1'b0, 3'd0, 3'd2, 3'd3, 1'b1, 16'h0f0f, Q);
        r.poke = 1'b1;
        rows.push_back(r);
        rows.push_back(make_row(SELB, 1'b0, 3'd0, 3'd3, 3'd7, 1'b0, '0, Q));
    endtask

    task automatic apply_row(input int idx, input row_t r);
        int   n;
        logic ok;
        ok = 1'b1;
        n  = 0;
        @(posedge clk);
        alu_op    <= r.op;
        is_8_bit  <= r.b8;
        ra_sel    <= r.ra;
        rb_sel    <= r.rb;
        rd_sel    <= r.rd;
        rb_cl     <= r.cl;
        use_imm   <= r.ui;
        imm       <= r.imm;
        wr_src    <= r.src;
        reg_wr_en <= r.we;
        start     <= 1'b1;
        @(posedge clk);
        if (r.poke) begin
            // Another start with other fields while the first op is in flight
            alu_op <= XOR;
            imm    <= ~r.imm;
            rd_sel <= r.rd + 3'd1;
        end else begin
            start <= 1'b0;
        end
        do begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) begin
            $display("row %0d: done never arrived within %0d cycles", idx, WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            if (!r.e_err && result !== r.e_res) begin
                $display("MISMATCH t=%0t result exp %h got %h", $time, r.e_res, result);
                ok = 1'b0;
            end
            if (flags !== r.e_flags) begin
                $display("MISMATCH t=%0t flags exp %h got %h", $time, r.e_flags, flags);
                ok = 1'b0;
            end
            if (div_error !== r.e_err) begin
                $display("MISMATCH t=%0t div_error exp %b got %b", $time, r.e_err, div_error);
                ok = 1'b0;
            end
            // Busy stays up through the done cycle
            if (busy !== 1'b1) begin
                $display("MISMATCH t=%0t busy exp 1 got %b", $time, busy);
                ok = 1'b0;
            end
            if (!(r.op inside {DIV, IDIV}) && n != 1) begin
                $display("row %0d: done came %0d cycles after start instead of 2", idx, n + 1);
                ok = 1'b0;
            end
            if (!ok) begin
                errors++;
            end
            $display("row %0d %s %0d-bit %s", idx, r.op.name(), r.b8 ? 8 : 16,
                     ok ? "ok" : "FAIL");
        end
    endtask

    initial begin
        void'($urandom(32'h6438ec94));
        clk       = 1'b0;
        arst_n    = 1'b0;
        start     = 1'b0;
        alu_op    = ADD;
        is_8_bit  = 1'b0;
        ra_sel    = '0;
        rb_sel    = '0;
        rd_sel    = '0;
        rb_cl     = 1'b0;
        use_imm   = 1'b0;
        imm       = '0;
        wr_src    = Q;
        reg_wr_en = 1'b0;
        errors    = 0;
        timed_out = 1'b0;
        mflags    = '0;
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end
        build_table();
        foreach (rows[i]) begin
            rows[i] = predict(rows[i]);
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            apply_row(i, rows[i]);
        end
        $display("rows %0d, failing rows %0d, timeout %0d, assertion failures %0d",
                 rows.size(), errors, timed_out, UUT.u_chk.fails);
        if (errors == 0 && !timed_out && UUT.u_chk.fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- core_slice.f
core_slice_pkg.sv
exec_if.sv
uop_decode.sv
register_file.sv
alu_execute.sv
divider.sv
result_writeback.sv
core_slice.sv
core_slice_chk.sv
tb_core_slice.sv
